/* verilog/uce_pkg.sv */
package uce_pkg;

  // fixed data cache geometry
  localparam int sets_lp               = 64;
  localparam int assoc_lp              = 8;
  localparam int block_width_lp        = 128;
  localparam int paddr_width_lp        = 32;
  localparam int dword_width_lp        = 64;
  localparam int block_offset_width_lp = $clog2(block_width_lp/8);
  localparam int index_width_lp        = $clog2(sets_lp);
  localparam int way_width_lp          = $clog2(assoc_lp);
  localparam int ptag_width_lp         = paddr_width_lp - index_width_lp - block_offset_width_lp;
  localparam int lce_id_width_lp       = 4;

  typedef logic [ptag_width_lp-1:0]  ptag_t;
  typedef logic [block_width_lp-1:0] block_t;

  typedef enum logic [2:0] {e_miss_load, e_miss_store, e_uc_load, e_uc_store} cache_req_type_e;

  typedef enum logic [2:0] {e_mem_rd, e_mem_wr, e_mem_uc_rd, e_mem_uc_wr, e_mem_wb} mem_msg_type_e;

  // log2 of the size in bytes
  typedef enum logic [2:0] {e_size_8 = 3'b011, e_size_64 = 3'b110} mem_size_e;

  typedef enum logic [1:0] {e_tag_set_clear, e_tag_read, e_tag_set_tag} tag_op_e;
  typedef enum logic [1:0] {e_data_read, e_data_write, e_data_uncached} data_op_e;
  typedef enum logic [1:0] {e_stat_set_clear, e_stat_clear_dirty} stat_op_e;
  typedef enum logic [1:0] {e_coh_i, e_coh_m} coh_state_e;

  typedef struct packed {
    cache_req_type_e             msg_type;
    logic [paddr_width_lp-1:0]   addr;
    mem_size_e                   size;
    logic [dword_width_lp-1:0]   data;
  } cache_req_s;

  typedef struct packed {
    logic [way_width_lp-1:0] repl_way;
    logic                    dirty;
  } cache_req_meta_s;

  typedef struct packed {
    tag_op_e                   opcode;
    logic [index_width_lp-1:0] index;
    logic [way_width_lp-1:0]   way;
    coh_state_e                state;
    ptag_t                     tag;
  } tag_pkt_s;

  typedef struct packed {
    data_op_e                  opcode;
    logic [index_width_lp-1:0] index;
    logic [way_width_lp-1:0]   way;
    block_t                    data;
  } data_pkt_s;

  typedef struct packed {
    stat_op_e                  opcode;
    logic [index_width_lp-1:0] index;
    logic [way_width_lp-1:0]   way;
  } stat_pkt_s;

  typedef struct packed {
    mem_msg_type_e              msg_type;
    logic [paddr_width_lp-1:0]  addr;
    mem_size_e                  size;
    logic [way_width_lp-1:0]    way;
    logic [lce_id_width_lp-1:0] lce_id;
    block_t                     data;
  } mem_msg_s;

endpackage

/* verilog/uce_req_if.sv */
`timescale 1ns/1ps

interface uce_req_if;
  import uce_pkg::*;

  // registered request, valid is one cycle behind the cache
  logic            req_v;
  cache_req_s      req;
  cache_req_meta_s meta;
  logic            meta_v;

  modport capture
  (
    output req_v, req, meta, meta_v
  );

  modport ctrl
  (
    input req_v, req, meta, meta_v
  );

endinterface

/* verilog/uce_req_capture.sv */
`timescale 1ns/1ps

module uce_req_capture
  (input                            clk_i
   , input                          reset_i
   , input uce_pkg::cache_req_s      cache_req_i
   , input                          cache_req_v_i
   , input uce_pkg::cache_req_meta_s cache_req_meta_i
   , input                          cache_req_meta_v_i
   , uce_req_if.capture             req_o
   );
  import uce_pkg::*;

  cache_req_s      req_r;
  cache_req_meta_s meta_r;
  logic            req_v_r;
  logic            meta_v_r;

  wire meta_v_en = cache_req_v_i | cache_req_meta_v_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      req_v_r  <= 1'b0;
      meta_v_r <= 1'b0;
    end
    else
    begin
      req_v_r <= cache_req_v_i;
      // a new request drops stale metadata unless it comes along
      if (meta_v_en)
        meta_v_r <= cache_req_meta_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_v_i)
      req_r <= cache_req_i;
    if (cache_req_meta_v_i)
      meta_r <= cache_req_meta_i;
  end

  assign req_o.req_v  = req_v_r;
  assign req_o.req    = req_r;
  assign req_o.meta   = cache_req_meta_v_i ? cache_req_meta_i : meta_r;
  assign req_o.meta_v = meta_v_en ? cache_req_meta_v_i : meta_v_r;

endmodule

/* verilog/uce_read_capture.sv */
`timescale 1ns/1ps

module uce_read_capture
  #(parameter type payload_t = logic)
  (input              clk_i
   , input            rd_v_i
   , input payload_t  rd_data_i
   , output payload_t data_o
   );

  logic     rd_v_r;
  payload_t data_r;

  // memory returns read data the cycle after the packet
  always_ff @(posedge clk_i)
  begin
    rd_v_r <= rd_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_v_r)
      data_r <= rd_data_i;
  end

  assign data_o = rd_v_r ? rd_data_i : data_r;

endmodule

/* verilog/uce_credit_counter.sv */
`timescale 1ns/1ps

module uce_credit_counter
  #(parameter int max_credits_p = 4)
  (input          clk_i
   , input        reset_i
   , input        cmd_v_i
   , input        cmd_ready_i
   , input        resp_yumi_i
   , output logic full_o
   , output logic empty_o
   );

  localparam int count_width_lp = $clog2(max_credits_p+1);

  logic [count_width_lp-1:0] count_r;

  wire cmd_sent = cmd_v_i & cmd_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else
      count_r <= count_r + count_width_lp'(cmd_sent) - count_width_lp'(resp_yumi_i);
  end

  assign full_o  = (count_r == count_width_lp'(max_credits_p));
  assign empty_o = (count_r == '0);

  // the cache must stall before a command would exceed the credit limit
  assert property (@(posedge clk_i) disable iff (reset_i)
    (full_o & cmd_sent) |-> resp_yumi_i)
    else $error("credit counter overflow");

  // a response with nothing outstanding
  assert property (@(posedge clk_i) disable iff (reset_i)
    empty_o |-> !resp_yumi_i)
    else $error("credit counter underflow");

endmodule

/* verilog/uce_ctrl.sv */
`timescale 1ns/1ps

module uce_ctrl
  (input                                   clk_i
   , input                                 reset_i
   , input [uce_pkg::lce_id_width_lp-1:0]  lce_id_i
   , input uce_pkg::cache_req_s             cache_req_i
   , input                                 cache_req_v_i
   , output logic                          cache_req_ready_o
   , uce_req_if.ctrl                       req_i
   , output logic                          cache_req_complete_o
   , output uce_pkg::tag_pkt_s              tag_pkt_o
   , output logic                          tag_pkt_v_o
   , input                                 tag_pkt_ready_i
   , output uce_pkg::data_pkt_s             data_pkt_o
   , output logic                          data_pkt_v_o
   , input                                 data_pkt_ready_i
   , output uce_pkg::stat_pkt_s             stat_pkt_o
   , output logic                          stat_pkt_v_o
   , input                                 stat_pkt_ready_i
   , input uce_pkg::ptag_t                  victim_tag_i
   , input uce_pkg::block_t                 victim_data_i
   , output uce_pkg::mem_msg_s              mem_cmd_o
   , output logic                          mem_cmd_v_o
   , input                                 mem_cmd_ready_i
   , input uce_pkg::mem_msg_s               mem_resp_i
   , input                                 mem_resp_v_i
   , output logic                          mem_resp_yumi_o
   );
  import uce_pkg::*;

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_send_req,
    e_writeback_read, e_writeback_req, e_read_wait, e_uc_read_wait
  } state_e;

  state_e                    state_r, state_n;
  logic [index_width_lp-1:0] index_r;
  logic                      index_up;
  logic                      mem_resp_yumi_lo;

  wire uc_store_v   = cache_req_v_i & (cache_req_i.msg_type == e_uc_store);
  wire store_resp_v = mem_resp_v_i & (mem_resp_i.msg_type inside {e_mem_uc_wr, e_mem_wb});
  wire load_resp_v  = mem_resp_v_i & (mem_resp_i.msg_type inside {e_mem_rd, e_mem_wr, e_mem_uc_rd});
  wire index_done   = (index_r == index_width_lp'(sets_lp-1));
  wire pkts_ready   = tag_pkt_ready_i & data_pkt_ready_i & stat_pkt_ready_i;
  wire fill_ready   = tag_pkt_ready_i & data_pkt_ready_i;

  wire [index_width_lp-1:0] req_index  = req_i.req.addr[block_offset_width_lp+:index_width_lp];
  wire [index_width_lp-1:0] resp_index = mem_resp_i.addr[block_offset_width_lp+:index_width_lp];
  wire ptag_t               resp_tag   =
    mem_resp_i.addr[block_offset_width_lp+index_width_lp+:ptag_width_lp];

  // write acks never stall the state machine
  assign mem_resp_yumi_o = mem_resp_yumi_lo | store_resp_v;

  always_comb
  begin
    cache_req_ready_o    = 1'b0;
    cache_req_complete_o = 1'b0;
    index_up             = 1'b0;
    tag_pkt_o            = '0;
    tag_pkt_v_o          = 1'b0;
    data_pkt_o           = '0;
    data_pkt_v_o         = 1'b0;
    stat_pkt_o           = '0;
    stat_pkt_v_o         = 1'b0;
    mem_cmd_o            = '0;
    mem_cmd_v_o          = 1'b0;
    mem_resp_yumi_lo     = 1'b0;
    state_n              = state_r;
    mem_cmd_o.lce_id     = lce_id_i;

    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_pkt_o.opcode     = e_tag_set_clear;
        tag_pkt_o.index      = index_r;
        tag_pkt_v_o          = tag_pkt_ready_i & stat_pkt_ready_i;
        stat_pkt_o.opcode    = e_stat_set_clear;
        stat_pkt_o.index     = index_r;
        stat_pkt_v_o         = tag_pkt_v_o;
        index_up             = tag_pkt_v_o;
        cache_req_complete_o = index_done & index_up;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        cache_req_ready_o = mem_cmd_ready_i;
        if (uc_store_v)
        begin
          // the store goes straight out and the controller stays in ready
          mem_cmd_o.msg_type = e_mem_uc_wr;
          mem_cmd_o.addr     = cache_req_i.addr;
          mem_cmd_o.size     = cache_req_i.size;
          mem_cmd_o.data     = block_t'(cache_req_i.data);
          mem_cmd_v_o        = mem_cmd_ready_i;
        end
        else if (cache_req_v_i & mem_cmd_ready_i)
          state_n = e_send_req;
      end
      e_send_req:
      begin
        mem_cmd_o.addr = req_i.req.addr;
        case (req_i.req.msg_type)
          e_miss_load, e_miss_store:
          begin
            mem_cmd_o.msg_type = (req_i.req.msg_type == e_miss_load) ? e_mem_rd : e_mem_wr;
            mem_cmd_o.size     = e_size_64;
            mem_cmd_o.way      = req_i.meta.repl_way;
            // the replacement way can trail the request by a cycle
            mem_cmd_v_o        = mem_cmd_ready_i & req_i.meta_v;
            if (mem_cmd_v_o)
              state_n = req_i.meta.dirty ? e_writeback_read : e_read_wait;
          end
          e_uc_load:
          begin
            mem_cmd_o.msg_type = e_mem_uc_rd;
            mem_cmd_o.size     = e_size_8;
            mem_cmd_v_o        = mem_cmd_ready_i;
            if (mem_cmd_v_o)
              state_n = e_uc_read_wait;
          end
          default:
            state_n = e_ready;
        endcase
      end
      e_writeback_read:
      begin
        tag_pkt_o.opcode  = e_tag_read;
        tag_pkt_o.index   = req_index;
        tag_pkt_o.way     = req_i.meta.repl_way;
        data_pkt_o.opcode = e_data_read;
        data_pkt_o.index  = req_index;
        data_pkt_o.way    = req_i.meta.repl_way;
        stat_pkt_o.opcode = e_stat_clear_dirty;
        stat_pkt_o.index  = req_index;
        stat_pkt_o.way    = req_i.meta.repl_way;
        tag_pkt_v_o       = pkts_ready;
        data_pkt_v_o      = pkts_ready;
        stat_pkt_v_o      = pkts_ready;
        if (pkts_ready)
          state_n = e_writeback_req;
      end
      e_writeback_req:
      begin
        mem_cmd_o.msg_type = e_mem_wb;
        mem_cmd_o.addr     = {victim_tag_i, req_index, {block_offset_width_lp{1'b0}}};
        mem_cmd_o.size     = e_size_64;
        mem_cmd_o.way      = req_i.meta.repl_way;
        mem_cmd_o.data     = victim_data_i;
        mem_cmd_v_o        = mem_cmd_ready_i;
        if (mem_cmd_v_o)
          state_n = e_read_wait;
      end
      e_read_wait:
      begin
        // fill in M so the line needs no further coherence traffic
        tag_pkt_o.opcode     = e_tag_set_tag;
        tag_pkt_o.index      = resp_index;
        tag_pkt_o.way        = mem_resp_i.way;
        tag_pkt_o.state      = e_coh_m;
        tag_pkt_o.tag        = resp_tag;
        data_pkt_o.opcode    = e_data_write;
        data_pkt_o.index     = resp_index;
        data_pkt_o.way       = mem_resp_i.way;
        data_pkt_o.data      = mem_resp_i.data;
        tag_pkt_v_o          = load_resp_v & fill_ready;
        data_pkt_v_o         = tag_pkt_v_o;
        cache_req_complete_o = tag_pkt_v_o;
        mem_resp_yumi_lo     = tag_pkt_v_o;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_pkt_o.opcode    = e_data_uncached;
        data_pkt_o.data      = mem_resp_i.data;
        data_pkt_v_o         = load_resp_v & data_pkt_ready_i;
        cache_req_complete_o = data_pkt_v_o;
        mem_resp_yumi_lo     = data_pkt_v_o;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      index_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (index_up)
        index_r <= index_r + 1'b1;
    end
  end

  // a request taken in ready is registered by the capture stage
  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == e_ready && state_n == e_send_req) |=> req_i.req_v)
    else $error("request not captured on entry to send_req");

endmodule

/* verilog/uce_top.sv */
`timescale 1ns/1ps

module uce_top
  #(parameter int max_credits_p = 4)
  (input                                   clk_i
   , input                                 reset_i
   , input [uce_pkg::lce_id_width_lp-1:0]  lce_id_i
   , input uce_pkg::cache_req_s             cache_req_i
   , input                                 cache_req_v_i
   , output logic                          cache_req_ready_o
   , input uce_pkg::cache_req_meta_s        cache_req_meta_i
   , input                                 cache_req_meta_v_i
   , output logic                          cache_req_complete_o
   , output uce_pkg::tag_pkt_s              tag_pkt_o
   , output logic                          tag_pkt_v_o
   , input                                 tag_pkt_ready_i
   , input uce_pkg::ptag_t                  tag_mem_i
   , output uce_pkg::data_pkt_s             data_pkt_o
   , output logic                          data_pkt_v_o
   , input                                 data_pkt_ready_i
   , input uce_pkg::block_t                 data_mem_i
   , output uce_pkg::stat_pkt_s             stat_pkt_o
   , output logic                          stat_pkt_v_o
   , input                                 stat_pkt_ready_i
   , output logic                          credits_full_o
   , output logic                          credits_empty_o
   , output uce_pkg::mem_msg_s              mem_cmd_o
   , output logic                          mem_cmd_v_o
   , input                                 mem_cmd_ready_i
   , input uce_pkg::mem_msg_s               mem_resp_i
   , input                                 mem_resp_v_i
   , output logic                          mem_resp_yumi_o
   );
  import uce_pkg::*;

  ptag_t  victim_tag;
  block_t victim_data;

  uce_req_if req_if();

  wire tag_rd_v  = tag_pkt_v_o & (tag_pkt_o.opcode == e_tag_read);
  wire data_rd_v = data_pkt_v_o & (data_pkt_o.opcode == e_data_read);

  uce_req_capture req_capture
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cache_req_i(cache_req_i)
     ,.cache_req_v_i(cache_req_v_i)
     ,.cache_req_meta_i(cache_req_meta_i)
     ,.cache_req_meta_v_i(cache_req_meta_v_i)
     ,.req_o(req_if)
     );

  uce_read_capture #(.payload_t(ptag_t)) victim_tag_capture
    (.clk_i(clk_i)
     ,.rd_v_i(tag_rd_v)
     ,.rd_data_i(tag_mem_i)
     ,.data_o(victim_tag)
     );

  uce_read_capture #(.payload_t(block_t)) victim_data_capture
    (.clk_i(clk_i)
     ,.rd_v_i(data_rd_v)
     ,.rd_data_i(data_mem_i)
     ,.data_o(victim_data)
     );

  uce_ctrl ctrl
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.lce_id_i(lce_id_i)
     ,.cache_req_i(cache_req_i)
     ,.cache_req_v_i(cache_req_v_i)
     ,.cache_req_ready_o(cache_req_ready_o)
     ,.req_i(req_if)
     ,.cache_req_complete_o(cache_req_complete_o)
     ,.tag_pkt_o(tag_pkt_o)
     ,.tag_pkt_v_o(tag_pkt_v_o)
     ,.tag_pkt_ready_i(tag_pkt_ready_i)
     ,.data_pkt_o(data_pkt_o)
     ,.data_pkt_v_o(data_pkt_v_o)
     ,.data_pkt_ready_i(data_pkt_ready_i)
     ,.stat_pkt_o(stat_pkt_o)
     ,.stat_pkt_v_o(stat_pkt_v_o)
     ,.stat_pkt_ready_i(stat_pkt_ready_i)
     ,.victim_tag_i(victim_tag)
     ,.victim_data_i(victim_data)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     );

  uce_credit_counter #(.max_credits_p(max_credits_p)) credit_counter
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(mem_cmd_v_o)
     ,.cmd_ready_i(mem_cmd_ready_i)
     ,.resp_yumi_i(mem_resp_yumi_o)
     ,.full_o(credits_full_o)
     ,.empty_o(credits_empty_o)
     );

endmodule

/* verification/tb_uce_top.sv */
`timescale 1ns/1ps

module tb_uce_top;
  import uce_pkg::*;

  localparam int max_credits_lp = 4;
  localparam int num_rows_lp    = 7;
  localparam int timeout_lp     = 200;

  typedef struct packed {
    cache_req_type_e req_type;
    logic [31:0]     addr;
    logic [63:0]     data;
    logic [2:0]      way;
    logic            dirty;
    mem_msg_type_e   exp_cmd;
  } row_s;

  // what the cache memory model returns for a victim read
  localparam ptag_t  model_tag  = 22'h2b6c1;
  localparam block_t model_line = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;

  logic            clk_i;
  logic            reset_i;
  logic [3:0]      lce_id_i;
  cache_req_s      cache_req_i;
  logic            cache_req_v_i;
  logic            cache_req_ready_o;
  cache_req_meta_s cache_req_meta_i;
  logic            cache_req_meta_v_i;
  logic            cache_req_complete_o;
  tag_pkt_s        tag_pkt_o;
  logic            tag_pkt_v_o;
  logic            tag_pkt_ready_i;
  ptag_t           tag_mem_i;
  data_pkt_s       data_pkt_o;
  logic            data_pkt_v_o;
  logic            data_pkt_ready_i;
  block_t          data_mem_i;
  stat_pkt_s       stat_pkt_o;
  logic            stat_pkt_v_o;
  logic            stat_pkt_ready_i;
  logic            credits_full_o;
  logic            credits_empty_o;
  mem_msg_s        mem_cmd_o;
  logic            mem_cmd_v_o;
  logic            mem_cmd_ready_i;
  mem_msg_s        mem_resp_i;
  logic            mem_resp_v_i;
  logic            mem_resp_yumi_o;

  row_s        rows [num_rows_lp];
  mem_msg_s    cmd_log [$];
  int          cmd_cyc [$];
  mem_msg_s    resp_q [$];
  int          due_q [$];
  tag_pkt_s    tag_log [$];
  data_pkt_s   data_log [$];
  stat_pkt_s   stat_log [$];
  int          cycle;
  int          clear_idx;
  int          complete_cnt;
  int          outstanding;
  int          err_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;
  logic        hold_resp;
  logic        tag_rd_seen;
  logic        data_rd_seen;
  logic [31:0] rng;

  uce_top #(.max_credits_p(max_credits_lp)) UUT (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every address bit shows up in the memory line
  function automatic block_t line_pattern(input logic [31:0] addr);
    return {addr ^ 32'ha5a5_0f0f, ~addr, addr + 32'h1234_5678, {addr[15:0], addr[31:16]}};
  endfunction

  function automatic mem_msg_s make_resp(input mem_msg_s cmd);
    mem_msg_s resp;
    resp = cmd;
    if (cmd.msg_type inside {e_mem_uc_wr, e_mem_wb})
      resp.data = '0;
    else
      resp.data = line_pattern(cmd.addr);
    return resp;
  endfunction

  task automatic compare(input string name, input logic [191:0] got, input logic [191:0] exp);
    check_count++;
    if (got !== exp)
    begin
      $display("** Error: %s = %0h, expected %0h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic end_run();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    err_count++;
  endtask

  task automatic report_test(input string name, input int e0);
    tests_run++;
    if (err_count != e0)
      tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (err_count == e0) ? "ok" : "failed");
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!cache_req_ready_o && n < timeout_lp)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!cache_req_ready_o)
      timeout_fail("cache_req_ready_o");
  endtask

  task automatic wait_cmd();
    int n;
    n = 0;
    while (cmd_log.size() == 0 && n < timeout_lp)
    begin
      @(negedge clk_i);
      n++;
    end
    if (cmd_log.size() == 0)
      timeout_fail("a memory command");
  endtask

  task automatic wait_pkts();
    int n;
    n = 0;
    while ((tag_log.size() == 0 || data_log.size() == 0 || stat_log.size() == 0)
           && n < timeout_lp)
    begin
      @(negedge clk_i);
      n++;
    end
    if (tag_log.size() == 0 || data_log.size() == 0 || stat_log.size() == 0)
      timeout_fail("the victim read packets");
  endtask

  task automatic wait_complete(input int target);
    int n;
    n = 0;
    while (complete_cnt < target && n < timeout_lp)
    begin
      @(negedge clk_i);
      n++;
    end
    if (complete_cnt < target)
      timeout_fail("cache_req_complete_o");
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (resp_q.size() != 0 && n < timeout_lp)
    begin
      @(negedge clk_i);
      n++;
    end
    if (resp_q.size() != 0)
      timeout_fail("the memory responses to drain");
  endtask

  // sampled at the rising edge before the DUT registers move
  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      if (cycle > 0)
        compare("outputs in reset", {tag_pkt_v_o, data_pkt_v_o, stat_pkt_v_o, mem_cmd_v_o,
                cache_req_ready_o, cache_req_complete_o, mem_resp_yumi_o}, '0);
    end
    else
    begin
      if (complete_cnt == 0)
        compare("cache_req_ready_o", cache_req_ready_o, 1'b0);
      if (tag_pkt_v_o && tag_pkt_o.opcode == e_tag_set_clear)
      begin
        compare("tag_pkt_o.index", tag_pkt_o.index, clear_idx);
        compare("stat_pkt_v_o", stat_pkt_v_o, 1'b1);
        compare("stat_pkt_o", {stat_pkt_o.opcode, stat_pkt_o.index},
                {e_stat_set_clear, clear_idx[5:0]});
        clear_idx++;
      end
      else
      begin
        if (tag_pkt_v_o)
          tag_log.push_back(tag_pkt_o);
        if (stat_pkt_v_o)
          stat_log.push_back(stat_pkt_o);
      end
      if (data_pkt_v_o)
        data_log.push_back(data_pkt_o);

      if (cache_req_complete_o)
      begin
        if (complete_cnt == 0)
          compare("clear count at complete", clear_idx, sets_lp);
        else
          compare("mem_resp_yumi_o", mem_resp_yumi_o, 1'b1);
        complete_cnt++;
      end

      compare("credits_empty_o", credits_empty_o, outstanding == 0);
      compare("credits_full_o", credits_full_o, outstanding == max_credits_lp);

      if (mem_resp_v_i && mem_resp_i.msg_type inside {e_mem_uc_wr, e_mem_wb})
        compare("mem_resp_yumi_o", mem_resp_yumi_o, 1'b1);
      else if (mem_resp_yumi_o)
        compare("cache_req_complete_o", cache_req_complete_o, 1'b1);

      if (mem_resp_yumi_o)
      begin
        compare("mem_resp_v_i", mem_resp_v_i, 1'b1);
        if (mem_resp_v_i && resp_q.size() > 0)
        begin
          void'(resp_q.pop_front());
          void'(due_q.pop_front());
          outstanding--;
        end
      end

      if (mem_cmd_v_o && mem_cmd_ready_i)
      begin
        rng = xorshift(rng);
        cmd_log.push_back(mem_cmd_o);
        cmd_cyc.push_back(cycle);
        resp_q.push_back(make_resp(mem_cmd_o));
        due_q.push_back(cycle + 3 + int'(rng % 7));
        outstanding++;
      end
    end
    tag_rd_seen  = tag_pkt_v_o && tag_pkt_o.opcode == e_tag_read;
    data_rd_seen = data_pkt_v_o && data_pkt_o.opcode == e_data_read;
    cycle++;
  end

  // memory responder and cache memory model
  always @(negedge clk_i)
  begin
    mem_resp_v_i = 1'b0;
    mem_resp_i   = '0;
    if (!hold_resp && resp_q.size() > 0)
    begin
      if (cycle >= due_q[0])
      begin
        mem_resp_v_i = 1'b1;
        mem_resp_i   = resp_q[0];
      end
    end
    tag_mem_i  = tag_rd_seen ? model_tag : '0;
    data_mem_i = data_rd_seen ? model_line : '0;
  end

  task automatic run_row(input row_s r);
    int         e0;
    int         c0;
    int         accept_cyc;
    logic [5:0] idx;
    ptag_t      tag;
    mem_msg_s   cmd;
    tag_pkt_s   tp;
    data_pkt_s  dp;
    stat_pkt_s  sp;
    e0  = err_count;
    c0  = complete_cnt;
    idx = r.addr[9:4];
    tag = r.addr[31:10];
    wait_ready();
    cache_req_i        = '{r.req_type, r.addr, e_size_8, r.data};
    cache_req_v_i      = 1'b1;
    cache_req_meta_i   = '{r.way, r.dirty};
    cache_req_meta_v_i = 1'b1;
    @(negedge clk_i);
    accept_cyc         = cycle - 1;
    cache_req_v_i      = 1'b0;
    cache_req_meta_v_i = 1'b0;

    wait_cmd();
    cmd = cmd_log.pop_front();
    compare("mem_cmd_o.msg_type", cmd.msg_type, r.exp_cmd);
    compare("mem_cmd_o.addr", cmd.addr, r.addr);
    compare("mem_cmd_o.lce_id", cmd.lce_id, lce_id_i);
    if (r.req_type == e_uc_store)
    begin
      compare("mem_cmd_o.size", cmd.size, e_size_8);
      compare("mem_cmd_o.data", cmd.data, {64'h0, r.data});
      compare("uc store command cycle", cmd_cyc.pop_front(), accept_cyc);
    end
    else
    begin
      void'(cmd_cyc.pop_front());
      if (r.req_type == e_uc_load)
        compare("mem_cmd_o.size", cmd.size, e_size_8);
      else
      begin
        compare("mem_cmd_o.size", cmd.size, e_size_64);
        compare("mem_cmd_o.way", cmd.way, r.way);
      end
    end

    // victim read and writeback
    if (r.dirty && r.req_type inside {e_miss_load, e_miss_store})
    begin
      wait_pkts();
      tp = tag_log.pop_front();
      dp = data_log.pop_front();
      sp = stat_log.pop_front();
      compare("tag_pkt_o", {tp.opcode, tp.index, tp.way}, {e_tag_read, idx, r.way});
      compare("data_pkt_o", {dp.opcode, dp.index, dp.way}, {e_data_read, idx, r.way});
      compare("stat_pkt_o", {sp.opcode, sp.index, sp.way}, {e_stat_clear_dirty, idx, r.way});
      wait_cmd();
      cmd = cmd_log.pop_front();
      void'(cmd_cyc.pop_front());
      compare("mem_cmd_o.msg_type", cmd.msg_type, e_mem_wb);
      compare("mem_cmd_o.addr", cmd.addr, {model_tag, idx, 4'h0});
      compare("mem_cmd_o.data", cmd.data, model_line);
      compare("mem_cmd_o.way", cmd.way, r.way);
    end

    if (r.req_type != e_uc_store)
    begin
      wait_complete(c0 + 1);
      dp = data_log.pop_front();
      if (r.req_type == e_uc_load)
        compare("data_pkt_o", {dp.opcode, dp.data}, {e_data_uncached, line_pattern(r.addr)});
      else
      begin
        tp = tag_log.pop_front();
        compare("tag_pkt_o", {tp.opcode, tp.index, tp.way, tp.state, tp.tag},
                {e_tag_set_tag, idx, r.way, e_coh_m, tag});
        compare("data_pkt_o", {dp.opcode, dp.index, dp.way, dp.data},
                {e_data_write, idx, r.way, line_pattern(r.addr)});
      end
    end
    wait_drain();
    compare("complete pulses", complete_cnt - c0, (r.req_type == e_uc_store) ? 0 : 1);
    compare("credits_empty_o", credits_empty_o, 1'b1);
    compare("unexpected packets or commands",
            tag_log.size() + data_log.size() + stat_log.size() + cmd_log.size(), 0);
    report_test(r.req_type.name(), e0);
  endtask

  task automatic run_credits();
    int e0;
    int n;
    e0 = err_count;
    wait_ready();
    hold_resp = 1'b1;
    for (n = 0; n < max_credits_lp; n++)
    begin
      cache_req_i   = '{e_uc_store, 32'h4000_0000 + 32'(n * 8), e_size_8, 64'(n)};
      cache_req_v_i = 1'b1;
      @(negedge clk_i);
    end
    cache_req_v_i = 1'b0;
    compare("credits_full_o", credits_full_o, 1'b1);
    compare("credits_empty_o", credits_empty_o, 1'b0);
    // responses fall due here but stay held back
    repeat (12) @(negedge clk_i);
    compare("credits_full_o", credits_full_o, 1'b1);
    compare("commands issued", cmd_log.size(), max_credits_lp);
    cmd_log.delete();
    cmd_cyc.delete();
    hold_resp = 1'b0;
    wait_drain();
    compare("credits_empty_o", credits_empty_o, 1'b1);
    compare("credits_full_o", credits_full_o, 1'b0);
    report_test("credits", e0);
  endtask

  initial
  begin
    clk_i              = 1'b0;
    reset_i            = 1'b1;
    lce_id_i           = 4'h5;
    cache_req_i        = '0;
    cache_req_v_i      = 1'b0;
    cache_req_meta_i   = '0;
    cache_req_meta_v_i = 1'b0;
    tag_pkt_ready_i    = 1'b1;
    data_pkt_ready_i   = 1'b1;
    stat_pkt_ready_i   = 1'b1;
    tag_mem_i          = '0;
    data_mem_i         = '0;
    mem_cmd_ready_i    = 1'b1;
    mem_resp_i         = '0;
    mem_resp_v_i       = 1'b0;
    hold_resp          = 1'b0;
    tag_rd_seen        = 1'b0;
    data_rd_seen       = 1'b0;
    rng                = 32'h33d;
    cycle              = 0;
    clear_idx          = 0;
    complete_cnt       = 0;
    outstanding        = 0;
    err_count          = 0;
    check_count        = 0;
    tests_run          = 0;
    tests_failed       = 0;

    rows[0] = '{e_uc_store,   32'h8000_1238, 64'hdead_beef_0123_4567, 3'd0, 1'b0, e_mem_uc_wr};
    rows[1] = '{e_uc_load,    32'h8000_2040, 64'h0,                   3'd0, 1'b0, e_mem_uc_rd};
    rows[2] = '{e_miss_load,  32'h1234_5670, 64'h0,                   3'd3, 1'b0, e_mem_rd};
    rows[3] = '{e_miss_store, 32'h0abc_d3f0, 64'h1111_2222_3333_4444, 3'd7, 1'b0, e_mem_wr};
    rows[4] = '{e_miss_load,  32'hfedc_ba90, 64'h0,                   3'd1, 1'b1, e_mem_rd};
    rows[5] = '{e_miss_store, 32'h0000_0410, 64'h5555_6666_7777_8888, 3'd5, 1'b1, e_mem_wr};
    rows[6] = '{e_uc_store,   32'h0000_fff8, 64'h0f0f_0f0f_f0f0_f0f0, 3'd2, 1'b1, e_mem_uc_wr};

    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    wait_complete(1);
    repeat (3) @(negedge clk_i);
    compare("set_clear indices", clear_idx, sets_lp);
    compare("complete pulses", complete_cnt, 1);
    report_test("reset_clear", 0);

    for (int i = 0; i < num_rows_lp; i++)
      run_row(rows[i]);
    run_credits();
    end_run();
  end

endmodule

/* sources.f */
verilog/uce_pkg.sv
verilog/uce_req_if.sv
verilog/uce_req_capture.sv
verilog/uce_read_capture.sv
verilog/uce_credit_counter.sv
verilog/uce_ctrl.sv
verilog/uce_top.sv
verification/tb_uce_top.sv

/* Makefile */
TOP = tb_uce_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
